// ==== src/rate_loop_pkg.sv ====
package rate_loop_pkg;

    // Sizes
    localparam int NUM_BEAMS = 2;
    localparam int THRESH_W  = 18;
    localparam int COUNT_W   = 32;
    localparam int ADR_W     = 22;
    localparam int DAT_W     = 32;

    typedef logic [THRESH_W-1:0] thresh_t;
    typedef logic [COUNT_W-1:0]  count_t;
    typedef logic [1:0]          beam_idx_t;   // Wide enough to hold NUM_BEAMS

    // Start-up values
    localparam thresh_t START_THRESH = 18'd4500;
    localparam count_t  START_TARGET = 32'd100;
    localparam count_t  START_DELTA  = 32'd2;
    localparam count_t  COUNT_MARGIN = 32'd10;   // Dead band around the target

    // Trigger side address map
    localparam logic [ADR_W-1:0] TRIG_CTRL_ADR  = 22'h000;
    localparam logic [ADR_W-1:0] TRIG_BEAM_BASE = 22'h400;
    localparam logic [ADR_W-1:0] TRIG_CE_BASE   = 22'h800;
    localparam logic [DAT_W-1:0] TRIG_START_CNT = 32'd1;
    localparam logic [DAT_W-1:0] TRIG_APPLY_ALL = 32'd2;

    // Host side address map
    localparam logic [ADR_W-1:0] REG_COUNT_BASE  = 22'h0400;
    localparam logic [ADR_W-1:0] REG_THRESH_BASE = 22'h0800;
    localparam logic [ADR_W-1:0] REG_CMD_ADR     = 22'h1000;
    localparam logic [ADR_W-1:0] REG_TARGET_ADR  = 22'h1004;
    localparam logic [ADR_W-1:0] REG_DELTA_ADR   = 22'h1008;

    typedef enum logic [1:0] {CMD_RESET = 2'd0, CMD_RUN = 2'd1, CMD_PAUSE = 2'd2} loop_cmd_e;

    typedef enum logic [2:0] {
        S_START, S_POLL, S_READ_COUNTS, S_CALC, S_WRITE_THRESH, S_ENABLE, S_APPLY
    } seq_state_e;

endpackage

// ==== src/bus_cmd_if.sv ====
`timescale 1ns/1ps

// One trigger bus operation handed from the sequencer to the bus master.
// req rises with the fields stable, ack answers, req drops, then ack drops.
interface bus_cmd_if import rate_loop_pkg::*; ();

    logic             req;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] wdat;
    logic             ack;
    logic [DAT_W-1:0] rdat;   // Valid while ack is high

    modport seq (
        output req, we, adr, wdat,
        input  ack, rdat
    );

    modport master (
        input  req, we, adr, wdat,
        output ack, rdat
    );

endinterface

// ==== src/loop_cfg_if.sv ====
`timescale 1ns/1ps

// Loop settings from the register block, read-back from the sequencer
interface loop_cfg_if import rate_loop_pkg::*; ();

    count_t    target;
    count_t    delta;
    logic      run_en;
    logic      reset_req;   // Single cycle pulse
    beam_idx_t rd_beam;
    count_t    rd_count;
    thresh_t   rd_thresh;

    modport regs (
        output target, delta, run_en, reset_req, rd_beam,
        input  rd_count, rd_thresh
    );

    modport seq (
        input  target, delta, run_en, reset_req, rd_beam,
        output rd_count, rd_thresh
    );

endinterface

// ==== src/loop_regs.sv ====
`timescale 1ns/1ps

module loop_regs import rate_loop_pkg::*; (
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [ADR_W-1:0] wb_adr_i,
    input  logic [DAT_W-1:0] wb_dat_i,
    output logic [DAT_W-1:0] wb_dat_o,
    output logic             wb_ack_o,
    loop_cfg_if.regs         cfg
);

    typedef enum logic [1:0] {R_IDLE, R_ACCESS, R_ACK} reg_state_e;

    reg_state_e       state;
    logic [DAT_W-1:0] rd_dat;
    logic             beam_ok;
    logic             is_count;
    logic             is_thresh;

    // Beam index sits in address bits 3:2 of both read-back windows
    assign cfg.rd_beam = wb_adr_i[3:2];
    assign beam_ok     = (cfg.rd_beam <= beam_idx_t'(NUM_BEAMS - 1));
    assign is_count    = (wb_adr_i[ADR_W-1:4] == REG_COUNT_BASE[ADR_W-1:4]) && beam_ok;
    assign is_thresh   = (wb_adr_i[ADR_W-1:4] == REG_THRESH_BASE[ADR_W-1:4]) && beam_ok;

    assign wb_ack_o = (state == R_ACK);
    assign wb_dat_o = rd_dat;

    //////////////////////////////
    // Access FSM
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state         <= R_IDLE;
            cfg.target    <= START_TARGET;
            cfg.delta     <= START_DELTA;
            cfg.run_en    <= 1'b1;   // Loop runs out of reset
            cfg.reset_req <= 1'b0;
        end else begin
            cfg.reset_req <= 1'b0;
            case (state)
                R_IDLE:   if (wb_cyc_i && wb_stb_i) state <= R_ACCESS;
                R_ACCESS: state <= R_ACK;
                default:  state <= R_IDLE;
            endcase

            // Writes land together with the ack
            if (state == R_ACCESS && wb_we_i) begin
                if (wb_adr_i == REG_CMD_ADR) begin
                    if (wb_dat_i == DAT_W'(CMD_RESET)) begin
                        cfg.reset_req <= 1'b1;
                        cfg.run_en    <= 1'b1;
                    end else if (wb_dat_i == DAT_W'(CMD_RUN)) begin
                        cfg.run_en <= 1'b1;
                    end else if (wb_dat_i == DAT_W'(CMD_PAUSE)) begin
                        cfg.run_en <= 1'b0;
                    end
                end else if (wb_adr_i == REG_TARGET_ADR) begin
                    cfg.target <= wb_dat_i;
                end else if (wb_adr_i == REG_DELTA_ADR) begin
                    cfg.delta <= wb_dat_i;
                end
            end
        end
    end

    // Read data, held through the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (state == R_ACCESS) begin
            if (is_count)                        rd_dat <= cfg.rd_count;
            else if (is_thresh)                  rd_dat <= DAT_W'(cfg.rd_thresh);
            else if (wb_adr_i == REG_TARGET_ADR) rd_dat <= cfg.target;
            else if (wb_adr_i == REG_DELTA_ADR)  rd_dat <= cfg.delta;
            else                                 rd_dat <= '0;   // Unmapped
        end
    end

endmodule

// ==== src/loop_sequencer.sv ====
`timescale 1ns/1ps

module loop_sequencer import rate_loop_pkg::*; (
    input  logic    wb_clk_i,
    input  logic    wb_rst_i,
    loop_cfg_if.seq cfg,
    bus_cmd_if.seq  cmd
);

    seq_state_e state;
    beam_idx_t  beam;
    logic       reset_pend;
    logic       load_start;

    count_t  counts  [NUM_BEAMS];   // Last counts read from the trigger
    thresh_t pending [NUM_BEAMS];   // Next thresholds to write
    thresh_t applied [NUM_BEAMS];   // Thresholds in force downstream

    count_t           cur_count;
    thresh_t          cur_pend;
    thresh_t          cur_thresh;
    thresh_t          next_thresh;
    logic [COUNT_W:0] up_sum;
    logic [ADR_W-1:0] beam_ofs;
    logic             last_beam;
    logic             can_issue;
    logic             op_done;
    logic             op_valid;
    logic             op_we;
    logic [ADR_W-1:0] op_adr;
    logic [DAT_W-1:0] op_wdat;

    // Current beam selects and host read-back
    always_comb begin
        cur_count     = '0;
        cur_pend      = '0;
        cur_thresh    = '0;
        cfg.rd_count  = '0;
        cfg.rd_thresh = '0;
        for (int b = 0; b < NUM_BEAMS; b++) begin
            if (beam == beam_idx_t'(b)) begin
                cur_count  = counts[b];
                cur_pend   = pending[b];
                cur_thresh = applied[b];
            end
            if (cfg.rd_beam == beam_idx_t'(b)) begin
                cfg.rd_count  = counts[b];
                cfg.rd_thresh = applied[b];
            end
        end
    end

    //////////////////////////////
    // Threshold step with saturation
    assign up_sum = (COUNT_W+1)'(cur_thresh) + (COUNT_W+1)'(cfg.delta);

    always_comb begin
        next_thresh = cur_thresh;   // Inside the dead band
        if ({1'b0, cur_count} > (COUNT_W+1)'(cfg.target) + (COUNT_W+1)'(COUNT_MARGIN)) begin
            next_thresh = (|up_sum[COUNT_W:THRESH_W]) ? '1 : up_sum[THRESH_W-1:0];
        end else if (cfg.target >= COUNT_MARGIN && cur_count < cfg.target - COUNT_MARGIN) begin
            next_thresh = (cfg.delta > COUNT_W'(cur_thresh)) ? '0
                                                             : cur_thresh - thresh_t'(cfg.delta);
        end
    end

    //////////////////////////////
    // Bus operation for each state
    assign beam_ofs   = ADR_W'({beam, 2'b00});
    assign last_beam  = (beam == beam_idx_t'(NUM_BEAMS - 1));
    assign can_issue  = !cmd.req && !cmd.ack;   // Previous handshake fully closed
    assign op_done    = cmd.req && cmd.ack;
    assign load_start = (state == S_START) && op_done && reset_pend;

    always_comb begin
        op_valid = 1'b1;
        op_we    = 1'b1;
        op_adr   = TRIG_CTRL_ADR;
        op_wdat  = '0;
        case (state)
            S_START:        op_wdat = TRIG_START_CNT;
            S_POLL:         op_we   = 1'b0;
            S_READ_COUNTS: begin
                op_we  = 1'b0;
                op_adr = TRIG_BEAM_BASE + beam_ofs;
            end
            S_WRITE_THRESH: begin
                op_adr  = TRIG_BEAM_BASE + beam_ofs;
                op_wdat = DAT_W'(cur_pend);
            end
            S_ENABLE: begin
                op_adr  = TRIG_CE_BASE + beam_ofs;
                op_wdat = DAT_W'(1'b1);
            end
            S_APPLY:        op_wdat = TRIG_APPLY_ALL;
            default:        op_valid = 1'b0;   // CALC stays off the bus
        endcase
    end

    //////////////////////////////
    // Loop FSM
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state      <= S_WRITE_THRESH;   // Push start thresholds first
            beam       <= '0;
            reset_pend <= 1'b0;
            cmd.req    <= 1'b0;
            cmd.we     <= 1'b0;
            for (int b = 0; b < NUM_BEAMS; b++) begin
                counts[b]  <= '0;
                pending[b] <= START_THRESH;
                applied[b] <= START_THRESH;
            end
        end else begin
            reset_pend <= cfg.reset_req || (reset_pend && !load_start);

            if (can_issue && op_valid) begin
                cmd.req  <= 1'b1;
                cmd.we   <= op_we;
                cmd.adr  <= op_adr;
                cmd.wdat <= op_wdat;
            end else if (op_done) begin
                cmd.req <= 1'b0;
            end

            case (state)
                S_START: if (op_done) begin
                    if (reset_pend) begin
                        for (int b = 0; b < NUM_BEAMS; b++) pending[b] <= START_THRESH;
                        beam  <= '0;
                        state <= S_WRITE_THRESH;
                    end else begin
                        state <= S_POLL;
                    end
                end
                S_POLL: if (op_done && cmd.rdat[0]) begin   // Count cycle finished
                    beam  <= '0;
                    state <= S_READ_COUNTS;
                end
                S_READ_COUNTS: if (op_done) begin
                    for (int b = 0; b < NUM_BEAMS; b++)
                        if (beam == beam_idx_t'(b)) counts[b] <= cmd.rdat;
                    beam  <= last_beam ? '0 : beam + 1'b1;
                    state <= last_beam ? S_CALC : S_READ_COUNTS;
                end
                S_CALC: begin
                    if (!cfg.run_en) begin   // Paused, keep counting only
                        beam  <= '0;
                        state <= S_START;
                    end else begin
                        for (int b = 0; b < NUM_BEAMS; b++)
                            if (beam == beam_idx_t'(b)) pending[b] <= next_thresh;
                        beam  <= last_beam ? '0 : beam + 1'b1;
                        state <= last_beam ? S_WRITE_THRESH : S_CALC;
                    end
                end
                S_WRITE_THRESH: if (op_done) begin
                    beam  <= last_beam ? '0 : beam + 1'b1;
                    state <= last_beam ? S_ENABLE : S_WRITE_THRESH;
                end
                S_ENABLE: if (op_done) begin
                    beam  <= last_beam ? '0 : beam + 1'b1;
                    state <= last_beam ? S_APPLY : S_ENABLE;
                end
                S_APPLY: if (op_done) begin
                    for (int b = 0; b < NUM_BEAMS; b++) applied[b] <= pending[b];
                    state <= S_START;
                end
                default: state <= S_START;
            endcase
        end
    end

endmodule

// ==== src/trig_bus_master.sv ====
`timescale 1ns/1ps

module trig_bus_master import rate_loop_pkg::*; (
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,
    bus_cmd_if.master        cmd,
    input  logic [DAT_W-1:0] trig_dat_i,
    input  logic             trig_ack_i,
    output logic             trig_cyc_o,
    output logic             trig_stb_o,
    output logic             trig_we_o,
    output logic [ADR_W-1:0] trig_adr_o,
    output logic [DAT_W-1:0] trig_dat_o
);

    typedef enum logic [1:0] {M_IDLE, M_BUS, M_DONE} master_state_e;

    master_state_e state;

    assign cmd.ack = (state == M_DONE);   // Held until req drops

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state      <= M_IDLE;
            trig_cyc_o <= 1'b0;
            trig_stb_o <= 1'b0;
            trig_we_o  <= 1'b0;
        end else begin
            case (state)
                M_IDLE: if (cmd.req) begin
                    trig_cyc_o <= 1'b1;
                    trig_stb_o <= 1'b1;
                    trig_we_o  <= cmd.we;
                    trig_adr_o <= cmd.adr;
                    trig_dat_o <= cmd.wdat;
                    state      <= M_BUS;
                end
                M_BUS: if (trig_ack_i) begin   // Trigger may stall here
                    trig_cyc_o <= 1'b0;
                    trig_stb_o <= 1'b0;
                    trig_we_o  <= 1'b0;
                    cmd.rdat   <= trig_dat_i;
                    state      <= M_DONE;
                end
                default: if (!cmd.req) state <= M_IDLE;
            endcase
        end
    end

endmodule

// ==== src/rate_loop_top.sv ====
`timescale 1ns/1ps

module rate_loop_top import rate_loop_pkg::*; (
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,
    // Host register port
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [ADR_W-1:0] wb_adr_i,
    input  logic [DAT_W-1:0] wb_dat_i,
    output logic [DAT_W-1:0] wb_dat_o,
    output logic             wb_ack_o,
    // Trigger bus
    output logic             trig_cyc_o,
    output logic             trig_stb_o,
    output logic             trig_we_o,
    output logic [ADR_W-1:0] trig_adr_o,
    output logic [DAT_W-1:0] trig_dat_o,
    input  logic [DAT_W-1:0] trig_dat_i,
    input  logic             trig_ack_i
);

    bus_cmd_if  cmd_bus ();
    loop_cfg_if cfg_bus ();

    loop_regs regs0 (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .cfg      (cfg_bus.regs)
    );

    loop_sequencer seq0 (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .cfg      (cfg_bus.seq),
        .cmd      (cmd_bus.seq)
    );

    trig_bus_master master0 (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .cmd        (cmd_bus.master),
        .trig_dat_i (trig_dat_i),
        .trig_ack_i (trig_ack_i),
        .trig_cyc_o (trig_cyc_o),
        .trig_stb_o (trig_stb_o),
        .trig_we_o  (trig_we_o),
        .trig_adr_o (trig_adr_o),
        .trig_dat_o (trig_dat_o)
    );

endmodule

// ==== verif/rate_loop_chk.sv ====
`timescale 1ns/1ps

module rate_loop_chk import rate_loop_pkg::*; (
    input logic             wb_clk_i,
    input logic             wb_rst_i,
    input logic             req_i,
    input logic             we_i,
    input logic [ADR_W-1:0] adr_i,
    input logic [DAT_W-1:0] wdat_i,
    input logic             ack_i,
    input logic             stb_i,
    input logic             bus_we_i,
    input logic [ADR_W-1:0] bus_adr_i,
    input logic [DAT_W-1:0] bus_dat_i,
    input logic             bus_ack_i,
    input logic             host_ack_i
);

    int fail_cnt = 0;   // Failed checks so far

    //////////////////////////////
    // Four-phase handshake
    req_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(req_i && !ack_i) |-> req_i)
        else begin
            $error("req dropped before ack");
            fail_cnt++;
        end

    // Fields stay put from the rise of req to the fall of ack
    fields_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (req_i || ack_i) && $past(req_i || ack_i) |-> $stable({we_i, adr_i, wdat_i}))
        else begin
            $error("request fields changed during a handshake");
            fail_cnt++;
        end

    ack_after_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $fell(ack_i) |-> !$past(req_i))
        else begin
            $error("ack fell while req was still high");
            fail_cnt++;
        end

    req_after_ack: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $rose(req_i) |-> !$past(ack_i))
        else begin
            $error("req rose again before ack fell");
            fail_cnt++;
        end

    //////////////////////////////
    // Trigger bus and host bus
    stb_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(stb_i && !bus_ack_i) |-> stb_i && $stable({bus_we_i, bus_adr_i, bus_dat_i}))
        else begin
            $error("trigger strobe or address changed before ack");
            fail_cnt++;
        end

    host_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(host_ack_i) |-> !host_ack_i)
        else begin
            $error("host ack longer than one cycle");
            fail_cnt++;
        end

endmodule

bind rate_loop_top rate_loop_chk chk0 (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .req_i      (cmd_bus.req),
    .we_i       (cmd_bus.we),
    .adr_i      (cmd_bus.adr),
    .wdat_i     (cmd_bus.wdat),
    .ack_i      (cmd_bus.ack),
    .stb_i      (trig_stb_o),
    .bus_we_i   (trig_we_o),
    .bus_adr_i  (trig_adr_o),
    .bus_dat_i  (trig_dat_o),
    .bus_ack_i  (trig_ack_i),
    .host_ack_i (wb_ack_o)
);

// ==== verif/rate_loop_tb.sv ====
`timescale 1ns/1ps

module rate_loop_tb import rate_loop_pkg::*; ();

    localparam int     ITER_CYCLES = 96;   // Ten bus operations of up to 9 cycles plus CALC
    localparam int     NUM_TESTS   = 6;
    localparam longint MAX_THRESH  = (longint'(1) << THRESH_W) - 1;

    logic             wb_clk_i = 1'b0;
    logic             wb_rst_i;
    logic             wb_cyc_i;
    logic             wb_stb_i;
    logic             wb_we_i;
    logic [ADR_W-1:0] wb_adr_i;
    logic [DAT_W-1:0] wb_dat_i;
    logic [DAT_W-1:0] wb_dat_o;
    logic             wb_ack_o;
    logic             trig_cyc_o;
    logic             trig_stb_o;
    logic             trig_we_o;
    logic [ADR_W-1:0] trig_adr_o;
    logic [DAT_W-1:0] trig_dat_o;
    logic [DAT_W-1:0] trig_dat_i;
    logic             trig_ack_i;

    count_t      count_tab [NUM_BEAMS];   // Counts the trigger reports
    thresh_t     thr_rec   [NUM_BEAMS];   // Last threshold written per beam
    int          thr_wr_cnt = 0;
    int          en_cnt     = 0;
    int          start_cnt  = 0;
    int          apply_cnt  = 0;
    int          polls      = 0;
    int unsigned seed       = 1330;
    longint      cur_target = START_TARGET;
    longint      cur_delta  = START_DELTA;
    int          errors     = 0;
    int          test_errs  = 0;
    int          ntests     = 0;
    string       cur_test   = "none";

    rate_loop_top dut0 (.*);

    always #2 wb_clk_i = ~wb_clk_i;

    // Host ack only answers an access in progress
    host_ack_valid: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |-> wb_cyc_i && wb_stb_i)
        else begin
            $display("%s: host ack seen without an active access", cur_test);
            errors++;
        end

    function automatic int unsigned next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    function automatic int total_errors();
        return errors + dut0.chk0.fail_cnt;
    endfunction

    // Threshold step rule with saturation at both ends
    function automatic thresh_t expect_thresh(input thresh_t base, input longint cnt);
        longint v;
        longint margin;
        margin = COUNT_MARGIN;
        v      = base;
        if (cnt > cur_target + margin) v = longint'(base) + cur_delta;
        else if (cnt < cur_target - margin) v = longint'(base) - cur_delta;
        if (v < 0) v = 0;
        if (v > MAX_THRESH) v = MAX_THRESH;
        return thresh_t'(v);
    endfunction

    task automatic check_val(input string what, input longint exp, input longint act);
        assert (exp == act) else begin
            $display("MISMATCH %s %s expected %0d actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = total_errors();
    endtask

    task automatic end_test();
        ntests++;
        $display("test %-9s %s", cur_test, (total_errors() == test_errs) ? "ok" : "FAILED");
    endtask

    //////////////////////////////
    // Host bus
    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat);
        @(posedge wb_clk_i);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        do begin
            @(posedge wb_clk_i);
            #1;
        end while (!wb_ack_o);
        @(posedge wb_clk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] dat);
        @(posedge wb_clk_i);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_adr_i = adr;
        do begin
            @(posedge wb_clk_i);
            #1;
        end while (!wb_ack_o);
        dat = wb_dat_o;   // Valid through the ack cycle
        @(posedge wb_clk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    //////////////////////////////
    // Trigger model
    task automatic serve_trig();
        int b;
        b = int'(trig_adr_o[3:2]);
        if (trig_we_o) begin
            if (trig_adr_o == TRIG_CTRL_ADR && trig_dat_o == TRIG_START_CNT) begin
                start_cnt++;
                polls = 0;
            end else if (trig_adr_o == TRIG_CTRL_ADR && trig_dat_o == TRIG_APPLY_ALL) begin
                apply_cnt++;
            end else if (trig_adr_o == TRIG_BEAM_BASE + ADR_W'(b * 4)) begin
                thr_rec[b] = trig_dat_o[THRESH_W-1:0];
                thr_wr_cnt++;
            end else if (trig_adr_o == TRIG_CE_BASE + ADR_W'(b * 4)) begin
                check_val($sformatf("enable%0d", b), 1, trig_dat_o);
                en_cnt++;
            end
        end else if (trig_adr_o == TRIG_CTRL_ADR) begin
            polls++;
            trig_dat_i = DAT_W'(polls >= 2);   // Done on the second poll
        end else begin
            trig_dat_i = count_tab[b];
        end
    endtask

    initial begin
        forever begin
            @(posedge wb_clk_i);
            #1;
            if (trig_cyc_o && trig_stb_o) begin
                repeat (next_rand() % 3) begin
                    @(posedge wb_clk_i);
                    #1;
                end
                serve_trig();
                trig_ack_i = 1'b1;
                @(posedge wb_clk_i);
                #1;
                trig_ack_i = 1'b0;
            end
        end
    end

    task automatic wait_applies(input int n);
        int goal;
        goal = apply_cnt + n;
        while (apply_cnt < goal) @(posedge wb_clk_i);
        repeat (3) @(posedge wb_clk_i);   // Apply ack reaches the sequencer two cycles later
    endtask

    task automatic wait_starts(input int n);
        int goal;
        goal = start_cnt + n;
        while (start_cnt < goal) @(posedge wb_clk_i);
    endtask

    // One count cycle that reads fresh counts, checked against the step rule
    task automatic run_iter(input count_t c0, input count_t c1);
        thresh_t          base [NUM_BEAMS];
        thresh_t          got  [NUM_BEAMS];
        logic [DAT_W-1:0] rd;
        wait_starts(1);   // Counts are read well after the start write
        count_tab[0] = c0;
        count_tab[1] = c1;
        base = thr_rec;   // Thresholds in force for this iteration
        wait_applies(1);
        got = thr_rec;
        for (int b = 0; b < NUM_BEAMS; b++) begin
            check_val($sformatf("thresh%0d", b), expect_thresh(base[b], count_tab[b]), got[b]);
            wb_read(REG_THRESH_BASE + ADR_W'(b * 4), rd);
            check_val($sformatf("rd_thresh%0d", b), got[b], rd);
            wb_read(REG_COUNT_BASE + ADR_W'(b * 4), rd);
            check_val($sformatf("rd_count%0d", b), count_tab[b], rd);
        end
    endtask

    //////////////////////////////
    // Tests
    initial begin
        logic [DAT_W-1:0] rd;
        int               snap;
        wb_rst_i     = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        trig_ack_i   = 1'b0;
        trig_dat_i   = '0;
        count_tab[0] = START_TARGET;
        count_tab[1] = START_TARGET;
        repeat (8) @(posedge wb_clk_i);
        #1;
        wb_rst_i = 1'b0;

        begin_test("reset");
        check_val("trig_cyc", 0, trig_cyc_o);
        check_val("wb_ack", 0, wb_ack_o);
        wait_applies(1);
        check_val("starts", 0, start_cnt);   // Thresholds go out before any count cycle
        check_val("writes", NUM_BEAMS, thr_wr_cnt);
        check_val("enables", NUM_BEAMS, en_cnt);
        for (int b = 0; b < NUM_BEAMS; b++) begin
            check_val($sformatf("thresh%0d", b), START_THRESH, thr_rec[b]);
            wb_read(REG_THRESH_BASE + ADR_W'(b * 4), rd);
            check_val($sformatf("rd_thresh%0d", b), START_THRESH, rd);
        end
        wb_read(REG_TARGET_ADR, rd);
        check_val("target", START_TARGET, rd);
        wb_read(REG_DELTA_ADR, rd);
        check_val("delta", START_DELTA, rd);
        wb_read(22'h1ffc, rd);
        check_val("unmapped", 0, rd);
        end_test();

        begin_test("step");
        run_iter(500, 800);   // Above the band
        run_iter(20, 50);     // Below the band
        run_iter(100, 105);   // Inside the band
        end_test();

        begin_test("config");
        wb_write(REG_TARGET_ADR, 1000);
        wb_write(REG_DELTA_ADR, 37);
        cur_target = 1000;
        cur_delta  = 37;
        wb_read(REG_TARGET_ADR, rd);
        check_val("target", cur_target, rd);
        wb_read(REG_DELTA_ADR, rd);
        check_val("delta", cur_delta, rd);
        run_iter(2000, 10);
        end_test();

        begin_test("saturate");
        wb_write(REG_DELTA_ADR, 32'h0010_0000);
        cur_delta = 32'h0010_0000;
        run_iter(5000, 9000);
        run_iter(0, 3);
        end_test();

        begin_test("pause");
        wb_write(REG_CMD_ADR, DAT_W'(CMD_PAUSE));
        wait_starts(1);   // An iteration past CALC may still finish its writes
        snap = thr_wr_cnt;
        wait_starts(3);
        check_val("paused writes", snap, thr_wr_cnt);
        wb_write(REG_CMD_ADR, DAT_W'(CMD_RUN));
        wait_applies(1);
        assert (thr_wr_cnt >= snap + NUM_BEAMS) else begin
            $display("%s: threshold writes did not resume after run", cur_test);
            errors++;
        end
        end_test();

        begin_test("cmd_reset");
        count_tab[0] = count_t'(cur_target);
        count_tab[1] = count_t'(cur_target);
        wb_write(REG_CMD_ADR, DAT_W'(CMD_RESET));
        wait_applies(2);
        for (int b = 0; b < NUM_BEAMS; b++) begin
            check_val($sformatf("thresh%0d", b), START_THRESH, thr_rec[b]);
            wb_read(REG_THRESH_BASE + ADR_W'(b * 4), rd);
            check_val($sformatf("rd_thresh%0d", b), START_THRESH, rd);
        end
        end_test();

        $display("%0d tests run, %0d errors", ntests, total_errors());
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized for eight iterations per test at the worst-case iteration length
    initial begin
        #(NUM_TESTS * 8 * ITER_CYCLES * 4);
        $display("Watchdog expired in test %s, the loop stopped making progress", cur_test);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== compile.f ====
src/rate_loop_pkg.sv
src/bus_cmd_if.sv
src/loop_cfg_if.sv
src/loop_regs.sv
src/loop_sequencer.sv
src/trig_bus_master.sv
src/rate_loop_top.sv
verif/rate_loop_chk.sv
verif/rate_loop_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run into sim.log and decide on the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rate_loop_tb \
    -f compile.f -o rate_loop_sim || { echo "build failed"; exit 1; }
./obj_dir/rate_loop_sim +verilator+error+limit+100 > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || { echo "run ended without a result"; exit 1; }
